//--- Makefile
# Verilator build and run of the level-two cache testbench

all: run

build:
	verilator --binary --timing -j 0 --top-module tb_l2_cache -f sources.f

run: build
	./obj_dir/Vtb_l2_cache | tee sim.log
	grep -q ">>> PASS" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module l2_cache_top \
		cache_geom_pkg.sv cache_ctrl_pkg.sv l2_way_arrays.sv l2_plru.sv \
		l2_hit_select.sv l2_beat_counter.sv l2_ctrl_fsm.sv l2_cache_top.sv

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

//--- cache_ctrl_pkg.sv
/*
 * Controller types for the level-two cache.
 * Holds the FSM state encoding and the packed structs of the requester
 * port, the memory port and the array write command.
 */

`default_nettype none

package cache_ctrl_pkg;
    import cache_geom_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        INSTALL,
        RESPOND
    } ctrl_state_e;

    typedef struct packed {
        logic      valid;
        logic      write;
        addr_t     addr;
        word_t     wdata;
    } cpu_req_t;

    typedef struct packed {
        logic      done;   // one cycle pulse
        word_t     rdata;
    } cpu_rsp_t;

    typedef struct packed {
        logic      valid;
        logic      write;
        mem_addr_t addr;
        word_t     wdata;
    } mem_req_t;

    typedef struct packed {
        logic      ready;  // beat done when valid and ready
        word_t     rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic      en;
        way_t      way;
        index_t    index;
        tag_t      tag;
        logic      dirty;
        line_t     line;
    } array_wr_t;

endpackage

`default_nettype wire

//--- cache_geom_pkg.sv
/*
 * Geometry of the four-way level-two cache.
 * Address field widths, line and word sizes and the vector types that
 * carry them. Modules that slice addresses or move lines import this
 * package in their header.
 */

`default_nettype none

package cache_geom_pkg;

    localparam int NUM_WAYS       = 4;
    localparam int NUM_SETS       = 16;
    localparam int WORDS_PER_LINE = 4;
    localparam int WORD_BITS      = 128;
    localparam int ADDR_BITS      = 32;
    localparam int OFFSET_BITS    = 6;   // byte offset in a line whose bits 5:4 pick the word
    localparam int INDEX_BITS     = 4;
    localparam int TAG_BITS       = 22;
    localparam int LINE_BITS      = 512;
    localparam int MEM_ADDR_BITS  = 28;  // word granular

    typedef logic [ADDR_BITS-1:0]                 addr_t;
    typedef logic [TAG_BITS-1:0]                  tag_t;
    typedef logic [INDEX_BITS-1:0]                index_t;
    typedef logic [$clog2(WORDS_PER_LINE)-1:0]    word_sel_t;
    typedef logic [$clog2(NUM_WAYS)-1:0]          way_t;
    typedef logic [NUM_WAYS-1:0]                  way_mask_t;
    typedef logic [WORD_BITS-1:0]                 word_t;
    typedef logic [LINE_BITS-1:0]                 line_t;
    typedef logic [NUM_WAYS-2:0]                  plru_t;     // three tree bits
    typedef logic [MEM_ADDR_BITS-1:0]             mem_addr_t;

endpackage

`default_nettype wire

//--- l2_beat_counter.sv
/*
 * Beat counter for line transfers on the 128-bit memory bus.
 * Counts accepted beats from zero, flags the fourth one and shifts each
 * returned word into the refill line, word 0 ending up lowest.
 */

`timescale 1ns/1ps
`default_nettype none

module l2_beat_counter
    import cache_geom_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      beat_start,
    input  logic      beat_accept,
    input  word_t     mem_rdata,
    output word_sel_t beat,
    output logic      beat_last,
    output line_t     fill_line
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            beat <= '0;
        end else if (beat_start) begin
            beat <= '0;
        end else if (beat_accept) begin
            beat <= beat + 1'b1;  // wraps after the last beat
        end
    end

    assign beat_last = beat_accept && (beat == word_sel_t'(WORDS_PER_LINE - 1));

    always_ff @(posedge clk) begin
        if (beat_accept) begin
            fill_line <= {mem_rdata, fill_line[LINE_BITS-1:WORD_BITS]};
        end
    end

endmodule

`default_nettype wire

//--- l2_cache_top.sv
/*
 * Four-way write-back level-two cache with one requester port and a
 * 128-bit memory bus. Connects the controller FSM, the beat counter,
 * the way arrays, the hit select logic and the PLRU.
 */

`timescale 1ns/1ps
`default_nettype none

module l2_cache_top
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  cpu_req_t cpu_req,
    output cpu_rsp_t cpu_rsp,
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp
);

    index_t    lookup_index;
    array_wr_t array_wr;
    tag_t      tags  [NUM_WAYS];
    line_t     lines [NUM_WAYS];
    way_mask_t valids;
    way_mask_t dirtys;
    logic      hit;
    way_t      hit_way;
    word_t     rd_word;
    line_t     merged_line;
    way_t      victim_way;
    logic      victim_dirty;
    tag_t      victim_tag;
    line_t     victim_line;
    logic      plru_touch;
    way_t      plru_way;
    logic      beat_start;
    logic      beat_accept;
    word_sel_t beat;
    logic      beat_last;
    line_t     fill_line;

    l2_ctrl_fsm u_fsm (
        .clk          (clk),
        .arst_n       (arst_n),
        .cpu_req      (cpu_req),
        .hit          (hit),
        .hit_way      (hit_way),
        .rd_word      (rd_word),
        .merged_line  (merged_line),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_line  (victim_line),
        .beat         (beat),
        .beat_last    (beat_last),
        .fill_line    (fill_line),
        .mem_rsp      (mem_rsp),
        .cpu_rsp      (cpu_rsp),
        .lookup_index (lookup_index),
        .array_wr     (array_wr),
        .plru_touch   (plru_touch),
        .plru_way     (plru_way),
        .beat_start   (beat_start),
        .beat_accept  (beat_accept),
        .mem_req      (mem_req)
    );

    l2_beat_counter u_beats (
        .clk         (clk),
        .arst_n      (arst_n),
        .beat_start  (beat_start),
        .beat_accept (beat_accept),
        .mem_rdata   (mem_rsp.rdata),
        .beat        (beat),
        .beat_last   (beat_last),
        .fill_line   (fill_line)
    );

    l2_way_arrays u_arrays (
        .clk          (clk),
        .arst_n       (arst_n),
        .lookup_index (lookup_index),
        .array_wr     (array_wr),
        .tags         (tags),
        .valids       (valids),
        .dirtys       (dirtys),
        .lines        (lines)
    );

    // request is held stable until done
    l2_hit_select u_hit (
        .req_addr     (cpu_req.addr),
        .req_wdata    (cpu_req.wdata),
        .tags         (tags),
        .valids       (valids),
        .dirtys       (dirtys),
        .lines        (lines),
        .fill_line    (fill_line),
        .victim_way   (victim_way),
        .hit          (hit),
        .hit_way      (hit_way),
        .rd_word      (rd_word),
        .merged_line  (merged_line),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_line  (victim_line)
    );

    l2_plru u_plru (
        .clk        (clk),
        .arst_n     (arst_n),
        .index      (lookup_index),
        .valids     (valids),
        .touch      (plru_touch),
        .touch_way  (plru_way),
        .victim_way (victim_way)
    );

endmodule

`default_nettype wire

//--- l2_ctrl_fsm.sv
/*
 * Sequencer of the level-two cache.
 * Takes a request in IDLE, compares tags in the second LOOKUP cycle,
 * writes back a dirty victim, refills the line beat by beat, installs it
 * and answers with a one cycle done. Also drives the memory bus address
 * and write data and the PLRU touch.
 */

`timescale 1ns/1ps
`default_nettype none

module l2_ctrl_fsm
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  cpu_req_t  cpu_req,
    input  logic      hit,
    input  way_t      hit_way,
    input  word_t     rd_word,
    input  line_t     merged_line,
    input  way_t      victim_way,
    input  logic      victim_dirty,
    input  tag_t      victim_tag,
    input  line_t     victim_line,
    input  word_sel_t beat,
    input  logic      beat_last,
    input  line_t     fill_line,
    input  mem_rsp_t  mem_rsp,
    output cpu_rsp_t  cpu_rsp,
    output index_t    lookup_index,
    output array_wr_t array_wr,
    output logic      plru_touch,
    output way_t      plru_way,
    output logic      beat_start,
    output logic      beat_accept,
    output mem_req_t  mem_req
);

    ctrl_state_e state, state_nxt;
    logic        compare;        // second LOOKUP cycle
    cpu_req_t    req_q;
    way_t        tgt_way;        // hit way or chosen victim
    word_t       rsp_word;
    tag_t        req_tag;
    index_t      req_index;

    assign req_tag      = req_q.addr[ADDR_BITS-1 -: TAG_BITS];
    assign req_index    = req_q.addr[OFFSET_BITS +: INDEX_BITS];
    assign lookup_index = (state == IDLE) ? cpu_req.addr[OFFSET_BITS +: INDEX_BITS] : req_index;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:      if (cpu_req.valid) state_nxt = LOOKUP;
            LOOKUP: begin
                if (compare) begin
                    if (hit) begin
                        state_nxt = req_q.write ? INSTALL : RESPOND;
                    end else begin
                        state_nxt = victim_dirty ? WRITEBACK : REFILL;
                    end
                end
            end
            WRITEBACK: if (beat_last) state_nxt = REFILL;
            REFILL:    if (beat_last) state_nxt = INSTALL;
            INSTALL:   state_nxt = RESPOND;
            RESPOND:   state_nxt = IDLE;
            default:   state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= IDLE;
            compare <= 1'b0;
            tgt_way <= '0;
        end else begin
            state   <= state_nxt;
            compare <= (state == LOOKUP) && !compare;
            if (state == LOOKUP && compare) begin
                tgt_way <= hit ? hit_way : victim_way;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && cpu_req.valid) begin
            req_q <= cpu_req;
        end
        if ((state == LOOKUP && compare) || state == INSTALL) begin
            rsp_word <= rd_word;  // hit word or word from the refill
        end
    end

    assign beat_start  = (state == LOOKUP) && compare && !hit;
    assign beat_accept = mem_req.valid && mem_rsp.ready;

    always_comb begin
        mem_req = '0;
        if (state == WRITEBACK) begin
            mem_req.valid = 1'b1;
            mem_req.write = 1'b1;
            mem_req.addr  = {victim_tag, req_index, beat};  // victim's own line
            mem_req.wdata = victim_line[beat*WORD_BITS +: WORD_BITS];
        end else if (state == REFILL) begin
            mem_req.valid = 1'b1;
            mem_req.addr  = {req_tag, req_index, beat};
        end
    end

    always_comb begin
        array_wr.en    = (state == INSTALL);
        array_wr.way   = tgt_way;
        array_wr.index = req_index;
        array_wr.tag   = req_tag;
        array_wr.dirty = req_q.write;
        array_wr.line  = req_q.write ? merged_line : fill_line;
    end

    assign plru_touch = (state == RESPOND);
    assign plru_way   = tgt_way;

    always_comb begin
        cpu_rsp.done  = (state == RESPOND);
        cpu_rsp.rdata = rsp_word;
    end

endmodule

`default_nettype wire

//--- l2_hit_select.sv
/*
 * Tag compare and data steering for one cache lookup.
 * Finds the hit way (lowest way wins), extracts the addressed word and
 * merges the write word into the hit line. With no hit the refill line
 * is used as the base instead. Also picks out the victim's tag, dirty
 * bit and data for a write-back.
 */

`timescale 1ns/1ps
`default_nettype none

module l2_hit_select
    import cache_geom_pkg::*;
(
    input  addr_t     req_addr,
    input  word_t     req_wdata,
    input  tag_t      tags  [NUM_WAYS],
    input  way_mask_t valids,
    input  way_mask_t dirtys,
    input  line_t     lines [NUM_WAYS],
    input  line_t     fill_line,          // base line when nothing hits
    input  way_t      victim_way,
    output logic      hit,
    output way_t      hit_way,
    output word_t     rd_word,
    output line_t     merged_line,
    output logic      victim_dirty,
    output tag_t      victim_tag,
    output line_t     victim_line
);

    tag_t      req_tag;
    word_sel_t word_sel;
    way_mask_t match;
    line_t     base_line;

    assign req_tag  = req_addr[ADDR_BITS-1 -: TAG_BITS];
    assign word_sel = req_addr[OFFSET_BITS-1 -: $bits(word_sel_t)];

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            match[w] = valids[w] && (tags[w] == req_tag);
        end
    end

    // walk downwards so the lowest matching way is left
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (match[w]) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    assign base_line = hit ? lines[hit_way] : fill_line;
    assign rd_word   = base_line[word_sel*WORD_BITS +: WORD_BITS];

    always_comb begin
        merged_line = base_line;
        merged_line[word_sel*WORD_BITS +: WORD_BITS] = req_wdata;
    end

    assign victim_dirty = valids[victim_way] && dirtys[victim_way];  // invalid never dirty
    assign victim_tag   = tags[victim_way];
    assign victim_line  = lines[victim_way];

endmodule

`default_nettype wire

//--- l2_plru.sv
/*
 * Tree pseudo-LRU replacement for the four-way cache.
 * Picks the lowest invalid way first, else walks the three tree bits of
 * the set. A touch points the tree away from the touched way.
 */

`timescale 1ns/1ps
`default_nettype none

module l2_plru
    import cache_geom_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  index_t    index,
    input  way_mask_t valids,
    input  logic      touch,
    input  way_t      touch_way,
    output way_t      victim_way
);

    plru_t tree [NUM_SETS];
    plru_t cur;

    assign cur = tree[index];

    always_comb begin
        if (!valids[0]) begin
            victim_way = way_t'(0);
        end else if (!valids[1]) begin
            victim_way = way_t'(1);
        end else if (!valids[2]) begin
            victim_way = way_t'(2);
        end else if (!valids[3]) begin
            victim_way = way_t'(3);
        end else if (!cur[0]) begin
            victim_way = cur[1] ? way_t'(1) : way_t'(0);  // left pair
        end else begin
            victim_way = cur[2] ? way_t'(3) : way_t'(2);  // right pair
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                tree[s] <= '0;
            end
        end else if (touch) begin
            case (touch_way)
                way_t'(0): tree[index] <= {cur[2], 1'b1, 1'b1};
                way_t'(1): tree[index] <= {cur[2], 1'b0, 1'b1};
                way_t'(2): tree[index] <= {1'b1, cur[1], 1'b0};
                default:   tree[index] <= {1'b0, cur[1], 1'b0};
            endcase
        end
    end

endmodule

`default_nettype wire

//--- l2_way_arrays.sv
/*
 * Tag, valid, dirty and data storage for the four cache ways.
 * All ways of the set on lookup_index are read out one cycle after the
 * index is given. A write command stores one way of one set at the next
 * edge and marks it valid.
 */

`timescale 1ns/1ps
`default_nettype none

module l2_way_arrays
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  index_t    lookup_index,
    input  array_wr_t array_wr,
    output tag_t      tags   [NUM_WAYS],
    output way_mask_t valids,
    output way_mask_t dirtys,
    output line_t     lines  [NUM_WAYS]
);

    tag_t      tag_mem   [NUM_WAYS][NUM_SETS];
    line_t     line_mem  [NUM_WAYS][NUM_SETS];
    logic      dirty_mem [NUM_WAYS][NUM_SETS];
    way_mask_t valid_mem [NUM_SETS];           // one bit per way

    // storage writes and synchronous read of tag, dirty and data
    always_ff @(posedge clk) begin
        if (array_wr.en) begin
            tag_mem[array_wr.way][array_wr.index]   <= array_wr.tag;
            line_mem[array_wr.way][array_wr.index]  <= array_wr.line;
            dirty_mem[array_wr.way][array_wr.index] <= array_wr.dirty;
        end
        for (int w = 0; w < NUM_WAYS; w++) begin
            tags[w]   <= tag_mem[w][lookup_index];
            lines[w]  <= line_mem[w][lookup_index];
            dirtys[w] <= dirty_mem[w][lookup_index];
        end
    end

    // valid bits start cleared
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_mem[s] <= '0;
            end
        end else if (array_wr.en) begin
            valid_mem[array_wr.index][array_wr.way] <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valids <= '0;
        end else begin
            valids <= valid_mem[lookup_index];
        end
    end

endmodule

`default_nettype wire

//--- sources.f
cache_geom_pkg.sv
cache_ctrl_pkg.sv
l2_way_arrays.sv
l2_plru.sv
l2_hit_select.sv
l2_beat_counter.sv
l2_ctrl_fsm.sv
l2_cache_top.sv
tb_mem_model.sv
tb_l2_cache.sv

//--- tb_l2_cache.sv
/*
 * Directed testbench for the level-two cache.
 * Runs read and write misses and hits, PLRU evictions with write-back
 * and a stalled memory. Each response and each memory beat is checked
 * against a small reference of tags, valid, dirty and tree bits.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_l2_cache
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 500;

    logic     clk;
    logic     arst_n;
    logic     stall_en;
    cpu_req_t cpu_req;
    cpu_rsp_t cpu_rsp;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    tag_t      ref_tag   [NUM_SETS][NUM_WAYS];
    logic      ref_dirty [NUM_SETS][NUM_WAYS];
    way_mask_t ref_valid [NUM_SETS];
    plru_t     ref_tree  [NUM_SETS];
    word_t     written   [mem_addr_t];        // last word stored per address

    l2_cache_top UUT (
        .clk     (clk),
        .arst_n  (arst_n),
        .cpu_req (cpu_req),
        .cpu_rsp (cpu_rsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    tb_mem_model mem_model (
        .clk      (clk),
        .stall_en (stall_en),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp)
    );

    always #50 clk = ~clk;

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compare_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAIL at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    function automatic word_t expected_word(input mem_addr_t a);
        if (written.exists(a)) return written[a];
        return mem_model.fill_word(a);
    endfunction

    function automatic addr_t line_addr(input tag_t t, input index_t s, input word_sel_t k);
        return {t, s, k, 4'h0};
    endfunction

    function automatic word_t random_word();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    // lowest invalid way first and then the tree bits
    function automatic way_t predict_victim(input index_t s);
        for (int i = 0; i < NUM_WAYS; i++) begin
            if (!ref_valid[s][i]) return way_t'(i);
        end
        if (!ref_tree[s][0]) return ref_tree[s][1] ? way_t'(1) : way_t'(0);
        return ref_tree[s][2] ? way_t'(3) : way_t'(2);
    endfunction

    // w[1] picks the pair and w[0] the way in it
    task automatic touch_way(input index_t s, input way_t w);
        ref_tree[s][0] = !w[1];
        if (!w[1]) begin
            ref_tree[s][1] = !w[0];
        end else begin
            ref_tree[s][2] = !w[0];
        end
    endtask

    task automatic access(input logic wr, input addr_t addr, input word_t wdata);
        index_t    s;
        tag_t      t;
        way_t      w;
        logic      hit;
        logic      wb;
        logic      done_seen;
        mem_addr_t base;
        mem_addr_t vbase;
        word_t     rdata;
        word_t     exp_rd;
        int        cycles;
        int        start;
        int        beats;
        s = addr[OFFSET_BITS +: INDEX_BITS];
        t = addr[ADDR_BITS-1 -: TAG_BITS];
        base = {t, s, 2'b00};
        hit = 1'b0;
        w = '0;
        for (int i = NUM_WAYS - 1; i >= 0; i--) begin
            if (ref_valid[s][i] && ref_tag[s][i] == t) begin
                hit = 1'b1;
                w = way_t'(i);
            end
        end
        wb = 1'b0;
        vbase = '0;
        if (!hit) begin
            w = predict_victim(s);
            wb = ref_valid[s][w] && ref_dirty[s][w];
            vbase = {ref_tag[s][w], s, 2'b00};    // victim's own line
        end
        exp_rd = expected_word(addr[ADDR_BITS-1 -: MEM_ADDR_BITS]);
        start = mem_model.log_addr.size();
        @(posedge clk);
        #1;
        cpu_req.valid = 1'b1;
        cpu_req.write = wr;
        cpu_req.addr  = addr;
        cpu_req.wdata = wdata;
        cycles = 0;
        done_seen = 1'b0;
        while (!done_seen) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cpu_rsp.done) begin
                done_seen = 1'b1;
            end else if (cycles >= TIMEOUT_CYCLES) begin
                $display("timeout: no done within %0d cycles for address %h", cycles, addr);
                abort_run();
            end
        end
        rdata = cpu_rsp.rdata;
        @(posedge clk);
        #1;
        cpu_req = '0;                               // drop valid after done
        if (!wr) begin
            compare_value("cpu_rsp.rdata", rdata, exp_rd);
        end
        if (hit && !wr) begin
            compare_value("read hit latency", word_t'(cycles), word_t'(3));
        end
        beats = (hit ? 0 : WORDS_PER_LINE) + (wb ? WORDS_PER_LINE : 0);
        compare_value("memory beat count", word_t'(mem_model.log_addr.size() - start),
                      word_t'(beats));
        if (wb) begin
            for (int i = 0; i < WORDS_PER_LINE; i++) begin
                compare_value("mem_req.write", word_t'(mem_model.log_wr[start + i]), word_t'(1));
                compare_value("mem_req.addr", word_t'(mem_model.log_addr[start + i]),
                              word_t'(vbase + mem_addr_t'(i)));
                compare_value("mem_req.wdata", mem_model.log_data[start + i],
                              expected_word(vbase + mem_addr_t'(i)));
            end
            start += WORDS_PER_LINE;
        end
        if (!hit) begin
            for (int i = 0; i < WORDS_PER_LINE; i++) begin
                compare_value("mem_req.write", word_t'(mem_model.log_wr[start + i]), '0);
                compare_value("mem_req.addr", word_t'(mem_model.log_addr[start + i]),
                              word_t'(base + mem_addr_t'(i)));
            end
        end
        if (wr) begin
            written[addr[ADDR_BITS-1 -: MEM_ADDR_BITS]] = wdata;
        end
        ref_dirty[s][w] = hit ? (ref_dirty[s][w] || wr) : wr;
        ref_tag[s][w]   = t;
        ref_valid[s][w] = 1'b1;
        touch_way(s, w);
    endtask

    task automatic read_miss_refill();
        access(1'b0, line_addr(22'h00123, 4'd3, 2'd2), '0);
    endtask

    task automatic read_hit_repeat();
        access(1'b0, line_addr(22'h00123, 4'd3, 2'd2), '0);
    endtask

    task automatic write_hit_merge();
        access(1'b1, line_addr(22'h00123, 4'd3, 2'd2),
               128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210);
        for (int k = 0; k < WORDS_PER_LINE; k++) begin
            access(1'b0, line_addr(22'h00123, 4'd3, word_sel_t'(k)), '0);
        end
    endtask

    // five tags in set 3 push the written line out
    task automatic plru_eviction();
        for (int k = 0; k < 4; k++) begin
            access(1'b0, line_addr(tag_t'(22'h200 + k), 4'd3, 2'd0), '0);
        end
        access(1'b0, line_addr(22'h00123, 4'd3, 2'd2), '0);
        access(1'b0, line_addr(22'h00200, 4'd3, 2'd1), '0);
        access(1'b0, line_addr(22'h00202, 4'd3, 2'd3), '0);
        access(1'b0, line_addr(22'h00203, 4'd3, 2'd0), '0);
    endtask

    task automatic stalled_memory();
        stall_en = 1'b1;
        for (int k = 0; k < 6; k++) begin
            access(1'b1, line_addr(tag_t'(22'h300 + k), 4'd9, word_sel_t'(k)), random_word());
        end
        for (int k = 0; k < 6; k++) begin
            access(1'b0, line_addr(tag_t'(22'h300 + k), 4'd9, word_sel_t'(k)), '0);
        end
        access(1'b0, line_addr(22'h00123, 4'd3, 2'd2), '0);
        stall_en = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h3531));
        clk      = 1'b0;
        arst_n   = 1'b0;
        stall_en = 1'b0;
        cpu_req  = '0;
        for (int s = 0; s < NUM_SETS; s++) begin
            ref_valid[s] = '0;
            ref_tree[s]  = '0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                ref_tag[s][w]   = '0;
                ref_dirty[s][w] = 1'b0;
            end
        end
        repeat (10) @(posedge clk);
        #1;
        arst_n = 1'b1;
        compare_value("cpu_rsp.done", word_t'(cpu_rsp.done), '0);
        compare_value("mem_req.valid", word_t'(mem_req.valid), '0);
        compare_value("fsm state", word_t'(UUT.u_fsm.state), word_t'(IDLE));
        read_miss_refill();
        read_hit_repeat();
        write_hit_merge();
        plru_eviction();
        stalled_memory();
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_mem_model.sv
/*
 * Behavioral memory for the cache testbench.
 * Answers the 128-bit bus with stored words or an address pattern,
 * pulls ready low at random while stall_en is high and logs every
 * accepted beat so that refills and write-backs can be checked.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_mem_model
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     stall_en,
    input  mem_req_t mem_req,
    output mem_rsp_t mem_rsp
);

    word_t     store [mem_addr_t];    // only words that were written back
    logic      ready_q = 1'b1;
    logic      log_wr   [$];
    mem_addr_t log_addr [$];
    word_t     log_data [$];

    // every word address gets its own content
    function automatic word_t fill_word(input mem_addr_t a);
        logic [31:0] x;
        x = {4'h0, a};
        return {~x, x ^ 32'hA5C3_5A3C, x * 32'h9E37_79B9, x};
    endfunction

    function automatic word_t read_word(input mem_addr_t a);
        if (store.exists(a)) return store[a];
        return fill_word(a);
    endfunction

    always_comb begin
        mem_rsp.ready = ready_q;
        mem_rsp.rdata = read_word(mem_req.addr);
    end

    always @(posedge clk) begin
        if (mem_req.valid && ready_q) begin
            log_wr.push_back(mem_req.write);
            log_addr.push_back(mem_req.addr);
            log_data.push_back(mem_req.write ? mem_req.wdata : read_word(mem_req.addr));
            if (mem_req.write) begin
                store[mem_req.addr] = mem_req.wdata;
            end
        end
        #1;
        ready_q = stall_en ? (($urandom & 32'd3) != 32'd0) : 1'b1;  // about one low in four
    end

endmodule

`default_nettype wire
